/* files.f */
hw/mem_pkg.sv
hw/mem_if.sv
hw/sram_sync.sv
hw/addr_counter.sv
hw/checksum_unit.sv
hw/mem_ctrl.sv
hw/mem_engine.sv
sim/tb_clkgen.sv
sim/tb_mem_engine.sv

/* hw/addr_counter.sv */
/*
 * Range walker for FILL and CHECKSUM.
 * Produces the current address, the element index and a last flag.
 */
`timescale 1ns/1ns

module addr_counter #(
	parameter int DEPTH = 256,
	localparam int ADDR_WIDTH = $clog2(DEPTH)
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  walk_load, // pulse, takes base and count.
	input  logic                  walk_step, // level, one element per cycle.
	input  logic [ADDR_WIDTH-1:0] base,
	input  logic [ADDR_WIDTH:0]   count,     // up to DEPTH elements.
	output logic [ADDR_WIDTH-1:0] addr,
	output logic [ADDR_WIDTH:0]   index,
	output logic                  last
);

	localparam logic [ADDR_WIDTH:0]   CNT_ONE = {{ADDR_WIDTH{1'b0}}, 1'b1};
	localparam logic [ADDR_WIDTH-1:0] ADDR_MAX = ADDR_WIDTH'(DEPTH - 1);

	logic [ADDR_WIDTH:0] remaining; // elements left including the current one.

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			addr      <= '0;
			index     <= '0;
			remaining <= '0;
		end else if (walk_load) begin
			addr      <= base;
			index     <= '0;
			remaining <= (count == '0) ? CNT_ONE : count; // zero means one.
		end else if (walk_step && (remaining != '0)) begin
			addr      <= (addr == ADDR_MAX) ? '0 : addr + 1'b1; // wrap at DEPTH.
			index     <= index + 1'b1;
			remaining <= remaining - 1'b1;
		end
	end

	assign last = (remaining == CNT_ONE);

endmodule

/* hw/checksum_unit.sv */
/*
 * Wrapping sum over a stream of SRAM read words.
 * Take flag is delayed one cycle to meet the read latency.
 */
`timescale 1ns/1ns

module checksum_unit #(
	parameter int WIDTH = 32
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             sum_clear, // pulse at command start.
	input  logic             sum_take,  // an address went out this cycle.
	input  logic [WIDTH-1:0] rdata,     // SRAM read port.
	output logic [WIDTH-1:0] sum
);

	logic take_q; // rdata now holds the word for last cycle's address.

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			take_q <= 1'b0;
		end else begin
			take_q <= sum_take;
		end
	end

	// one word in flight while the next address is presented.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sum <= '0;
		end else if (sum_clear) begin
			sum <= '0;
		end else if (take_q) begin
			sum <= sum + rdata; // modulo 2^WIDTH.
		end
	end

endmodule

/* hw/mem_ctrl.sv */
/*
 * Command FSM of the memory engine.
 * Latches a host command, drives the SRAM port, walker and accumulator,
 * and returns done plus the registered READ word.
 */
`timescale 1ns/1ns

module mem_ctrl
	import mem_pkg::*;
#(
	parameter int WIDTH = 32,
	parameter int DEPTH = 256,
	localparam int ADDR_WIDTH = $clog2(DEPTH),
	localparam int LANES = lanes_of(WIDTH)
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  start,
	input  mem_op_e               op,
	input  logic [ADDR_WIDTH-1:0] addr,
	input  logic [ADDR_WIDTH:0]   count,
	input  logic [WIDTH-1:0]      wdata,
	input  logic [LANES-1:0]      wmask,
	output logic                  busy,
	output logic                  done,
	output logic [WIDTH-1:0]      rdata,
	output logic                  walk_load,
	output logic                  walk_step,
	output logic [ADDR_WIDTH-1:0] walk_base,
	output logic [ADDR_WIDTH:0]   walk_count,
	input  logic [ADDR_WIDTH-1:0] walk_addr,
	input  logic [ADDR_WIDTH:0]   walk_index,
	input  logic                  walk_last,
	output logic                  sum_clear,
	output logic                  sum_take,
	mem_if.ctrl                   mem
);

	ctrl_state_e state;
	ctrl_state_e state_nxt;

	logic                  accept;    // start taken, only when idle.
	logic                  range_op;  // FILL or CHECKSUM.
	logic                  rd_valid;  // read address went out last cycle.
	logic [ADDR_WIDTH-1:0] cmd_addr;
	logic [WIDTH-1:0]      cmd_wdata; // WRITE word or FILL pattern base.
	logic [LANES-1:0]      cmd_wmask;

	assign accept   = start && (state == ST_IDLE); // start while busy is dropped.
	assign range_op = (op == OP_FILL) || (op == OP_CHECKSUM);

	// walker loads straight from the host fields on the start cycle.
	assign walk_load  = accept && range_op;
	assign walk_base  = addr;
	assign walk_count = count;
	assign walk_step  = (state == ST_FILL) || (state == ST_SUM);

	assign sum_clear = accept && (op == OP_CHECKSUM);
	assign sum_take  = (state == ST_SUM); // one address per cycle.

	assign busy = (state != ST_IDLE);

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				if (start) begin
					case (op)
						OP_READ:     state_nxt = ST_READ;
						OP_WRITE:    state_nxt = ST_WRITE;
						OP_FILL:     state_nxt = ST_FILL;
						OP_CHECKSUM: state_nxt = ST_SUM;
						default:     state_nxt = ST_IDLE;
					endcase
				end
			end
			ST_READ:      state_nxt = ST_READ_WAIT;
			ST_READ_WAIT: if (rd_valid) state_nxt = ST_IDLE;  // word is on rdata.
			ST_WRITE:     state_nxt = ST_IDLE;
			ST_FILL:      if (walk_last) state_nxt = ST_IDLE;
			ST_SUM:       if (walk_last) state_nxt = ST_SUM_DRAIN;
			ST_SUM_DRAIN: state_nxt = ST_IDLE;                // accumulator takes last word.
			default:      state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= ST_IDLE;
			done     <= 1'b0;
			rd_valid <= 1'b0;
		end else begin
			state    <= state_nxt;
			done     <= busy && (state_nxt == ST_IDLE); // one pulse per command.
			rd_valid <= (state == ST_READ_WAIT);
		end
	end

	// command fields, held for the whole command.
	always_ff @(posedge clk) begin
		if (accept) begin
			cmd_addr  <= addr;
			cmd_wdata <= wdata;
			cmd_wmask <= wmask;
		end
	end

	// READ result holds until the next READ completes.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rdata <= '0;
		end else if ((state == ST_READ_WAIT) && rd_valid) begin
			rdata <= mem.rdata;
		end
	end

	// SRAM port source select.
	always_comb begin
		mem.addr  = cmd_addr;
		mem.wdata = cmd_wdata;
		mem.wen   = '0;
		case (state)
			ST_WRITE: begin
				mem.wen = cmd_wmask;
			end
			ST_FILL: begin
				mem.addr  = walk_addr;
				mem.wdata = cmd_wdata + WIDTH'(walk_index); // pattern plus offset.
				mem.wen   = '1;                             // all lanes.
			end
			ST_SUM: begin
				mem.addr = walk_addr;
			end
			default: begin
				mem.wen = '0; // reads only.
			end
		endcase
	end

endmodule

/* hw/mem_engine.sv */
/*
 * Top level of the on-chip memory engine.
 * Host command ports in, busy, done, READ word and checksum out.
 * Holds the FSM, the SRAM, the range walker and the accumulator.
 */
`timescale 1ns/1ns

module mem_engine
	import mem_pkg::*;
#(
	parameter int WIDTH = 32,
	parameter int DEPTH = 256,
	localparam int ADDR_WIDTH = $clog2(DEPTH),
	localparam int LANES = lanes_of(WIDTH)
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  start,  // one-cycle pulse while idle.
	input  mem_op_e               op,
	input  logic [ADDR_WIDTH-1:0] addr,   // word address or range base.
	input  logic [ADDR_WIDTH:0]   count,  // range length, zero acts as one.
	input  logic [WIDTH-1:0]      wdata,
	input  logic [LANES-1:0]      wmask,
	output logic                  busy,
	output logic                  done,
	output logic [WIDTH-1:0]      rdata,  // last READ result.
	output logic [WIDTH-1:0]      sum     // last CHECKSUM result.
);

	logic                  walk_load;
	logic                  walk_step;
	logic [ADDR_WIDTH-1:0] walk_base;
	logic [ADDR_WIDTH:0]   walk_count;
	logic [ADDR_WIDTH-1:0] walk_addr;
	logic [ADDR_WIDTH:0]   walk_index;
	logic                  walk_last;
	logic                  sum_clear;
	logic                  sum_take;

	mem_if #(
		.WIDTH (WIDTH),
		.DEPTH (DEPTH)
	) mem_bus ();

	mem_ctrl #(
		.WIDTH (WIDTH),
		.DEPTH (DEPTH)
	) u_mem_ctrl (
		.clk        (clk),
		.arst_n     (arst_n),
		.start      (start),
		.op         (op),
		.addr       (addr),
		.count      (count),
		.wdata      (wdata),
		.wmask      (wmask),
		.busy       (busy),
		.done       (done),
		.rdata      (rdata),
		.walk_load  (walk_load),
		.walk_step  (walk_step),
		.walk_base  (walk_base),
		.walk_count (walk_count),
		.walk_addr  (walk_addr),
		.walk_index (walk_index),
		.walk_last  (walk_last),
		.sum_clear  (sum_clear),
		.sum_take   (sum_take),
		.mem        (mem_bus.ctrl)
	);

	sram_sync #(
		.WIDTH       (WIDTH),
		.DEPTH       (DEPTH),
		.BYTE_ENABLE (1'b1)
	) u_sram_sync (
		.clk  (clk),
		.port (mem_bus.mem)
	);

	addr_counter #(
		.DEPTH (DEPTH)
	) u_addr_counter (
		.clk       (clk),
		.arst_n    (arst_n),
		.walk_load (walk_load),
		.walk_step (walk_step),
		.base      (walk_base),
		.count     (walk_count),
		.addr      (walk_addr),
		.index     (walk_index),
		.last      (walk_last)
	);

	checksum_unit #(
		.WIDTH (WIDTH)
	) u_checksum_unit (
		.clk       (clk),
		.arst_n    (arst_n),
		.sum_clear (sum_clear),
		.sum_take  (sum_take),
		.rdata     (mem_bus.rdata), // tapped off the SRAM read port.
		.sum       (sum)
	);

endmodule

/* hw/mem_if.sv */
/*
 * SRAM port bundle between the controller and the memory.
 * ctrl modport drives address, data and lane enables.
 * mem modport returns the registered read word.
 */
`timescale 1ns/1ns

interface mem_if
	import mem_pkg::*;
#(
	parameter int WIDTH = 32,
	parameter int DEPTH = 256
) ();

	localparam int ADDR_WIDTH = $clog2(DEPTH);
	localparam int LANES = lanes_of(WIDTH);

	logic [LANES-1:0]      wen;   // one enable per byte lane.
	logic [ADDR_WIDTH-1:0] addr;  // shared read/write address.
	logic [WIDTH-1:0]      wdata;
	logic [WIDTH-1:0]      rdata; // word at last cycle's addr, pre-write.

	modport ctrl (output wen, addr, wdata, input rdata);
	modport mem (input wen, addr, wdata, output rdata);

endinterface

/* hw/mem_pkg.sv */
/*
 * Shared definitions for the memory engine.
 * mem_op_e      host command opcodes.
 * ctrl_state_e  command FSM states.
 * lanes_of      byte lanes in a data word.
 */
package mem_pkg;

	typedef enum logic [1:0] {
		OP_READ     = 2'd0, // single word read.
		OP_WRITE    = 2'd1, // single word write under byte mask.
		OP_FILL     = 2'd2, // incrementing pattern over a range.
		OP_CHECKSUM = 2'd3  // modular sum over a range.
	} mem_op_e;

	typedef enum logic [2:0] {
		ST_IDLE      = 3'd0,
		ST_READ      = 3'd1, // turnaround before the read address goes out.
		ST_READ_WAIT = 3'd2, // address out, then data back from the SRAM.
		ST_WRITE     = 3'd3,
		ST_FILL      = 3'd4,
		ST_SUM       = 3'd5,
		ST_SUM_DRAIN = 3'd6  // last word still in flight.
	} ctrl_state_e;

	// narrow words still get one lane.
	function automatic int unsigned lanes_of(input int unsigned width);
		return (width < 8) ? 1 : width / 8;
	endfunction

endpackage

/* hw/sram_sync.sv */
/*
 * Inferred single-port synchronous SRAM.
 * One-cycle registered read, read-before-write on a shared address.
 * Per-lane write enables, or one enable when BYTE_ENABLE is 0.
 */
`timescale 1ns/1ns

module sram_sync
	import mem_pkg::*;
#(
	parameter int WIDTH = 32,
	parameter int DEPTH = 256,
	parameter bit BYTE_ENABLE = 1
) (
	input logic clk,
	mem_if.mem  port
);

	localparam int LANES = lanes_of(WIDTH);

	logic [WIDTH-1:0] mem_array [DEPTH]; // storage, no reset.

	// start from a known all-zero image.
	initial begin
		for (int n = 0; n < DEPTH; n++) begin
			mem_array[n] = '0;
		end
	end

	generate
		if (BYTE_ENABLE) begin : g_lane_we
			always @(posedge clk) begin
				for (int i = 0; i < LANES; i++) begin
					if (port.wen[i]) begin
						mem_array[port.addr][8*i +: 8] <= port.wdata[8*i +: 8]; // this lane only.
					end
				end
			end
		end else begin : g_word_we
			logic wen_any;

			assign wen_any = |port.wen; // mask collapses to one enable.

			always @(posedge clk) begin
				if (wen_any) begin
					mem_array[port.addr] <= port.wdata; // whole word.
				end
			end
		end
	endgenerate

	// read register samples the array before this edge's write lands.
	always_ff @(posedge clk) begin
		port.rdata <= mem_array[port.addr];
	end

endmodule

/* run.sh */
#!/bin/sh
# Build the memory engine testbench with Verilator and run it.
# Exit status is nonzero on a build error, a crash or a reported failure.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/sim_mem_engine

verilator --binary --timing --assert -Wno-fatal \
	-f files.f --top-module tb_mem_engine -Mdir obj_dir -o sim_mem_engine
if [ $? -ne 0 ]; then
	echo "run.sh: verilator build failed"
	exit 1
fi

"./$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "run.sh: simulation exited with status $status"
	exit 1
fi

if grep -q "Verification failed" "$LOG"; then
	echo "run.sh: result FAIL"
	exit 1
fi

echo "run.sh: result PASS"
exit 0

/* sim/tb_clkgen.sv */
/*
 * Testbench clock and reset source.
 * 20 ns clock, active low reset held for 16 rising edges.
 */
`timescale 1ns/1ns

module tb_clkgen #(
	parameter int PERIOD     = 20,
	parameter int RST_CYCLES = 16
) (
	output logic clk,
	output logic arst_n
);

	initial clk = 1'b0;

	always #(PERIOD / 2) clk = ~clk; // free running.

	initial begin
		arst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1; // release away from the active edge.
	end

endmodule

/* sim/tb_mem_engine.sv */
/*
 * Testbench top for the memory engine.
 * Command table with expected READ words, sums and done latencies,
 * a shadow memory that fills in the expectations, and the apply loop.
 */
`timescale 1ns/1ns

module tb_mem_engine
	import mem_pkg::*;
();

	localparam int WIDTH      = 32;
	localparam int DEPTH      = 256;
	localparam int ADDR_WIDTH = $clog2(DEPTH);
	localparam int CNT_WIDTH  = ADDR_WIDTH + 1;
	localparam int LANES      = WIDTH / 8;
	localparam int MAX_ROWS   = 80;
	localparam int WAIT_LIMIT = 1000; // cycles, above a full-depth checksum.

	logic                  clk;
	logic                  arst_n;
	logic                  start;
	mem_op_e               op;
	logic [ADDR_WIDTH-1:0] addr;
	logic [CNT_WIDTH-1:0]  count;
	logic [WIDTH-1:0]      wdata;
	logic [LANES-1:0]      wmask;
	logic                  busy;
	logic                  done;
	logic [WIDTH-1:0]      rdata;
	logic [WIDTH-1:0]      sum;

	// command table, expectations filled in by the shadow pass.
	string                 row_name      [MAX_ROWS];
	mem_op_e               row_op        [MAX_ROWS];
	logic [ADDR_WIDTH-1:0] row_addr      [MAX_ROWS];
	logic [CNT_WIDTH-1:0]  row_count     [MAX_ROWS];
	logic [WIDTH-1:0]      row_wdata     [MAX_ROWS];
	logic [LANES-1:0]      row_wmask     [MAX_ROWS];
	bit                    row_stray     [MAX_ROWS]; // extra start pulse while busy.
	logic [WIDTH-1:0]      row_exp_rdata [MAX_ROWS];
	logic [WIDTH-1:0]      row_exp_sum   [MAX_ROWS];
	int                    row_exp_lat   [MAX_ROWS]; // cycles from start sample to done.
	int                    n_rows;

	logic [WIDTH-1:0] shadow [DEPTH]; // reference image of the SRAM.

	int seed = 32'h7d06;
	int value_errors;
	int timeout_errors;
	int checks_run;

	tb_clkgen u_tb_clkgen (
		.clk    (clk),
		.arst_n (arst_n)
	);

	mem_engine #(
		.WIDTH (WIDTH),
		.DEPTH (DEPTH)
	) u_mem_engine (
		.clk    (clk),
		.arst_n (arst_n),
		.start  (start),
		.op     (op),
		.addr   (addr),
		.count  (count),
		.wdata  (wdata),
		.wmask  (wmask),
		.busy   (busy),
		.done   (done),
		.rdata  (rdata),
		.sum    (sum)
	);

	task automatic add_row(input string name, input mem_op_e o, input int a, input int c,
			input logic [WIDTH-1:0] d, input logic [LANES-1:0] m, input bit stray);
		if (n_rows >= MAX_ROWS) begin
			$display("Command table is full, row %s dropped", name);
			value_errors++;
		end else begin
			row_name[n_rows]  = name;
			row_op[n_rows]    = o;
			row_addr[n_rows]  = ADDR_WIDTH'(a);
			row_count[n_rows] = CNT_WIDTH'(c);
			row_wdata[n_rows] = d;
			row_wmask[n_rows] = m;
			row_stray[n_rows] = stray;
			n_rows++;
		end
	endtask

	// walk the table through the shadow memory; stray starts leave no trace.
	task automatic build_expected();
		logic [WIDTH-1:0] last_rd;
		logic [WIDTH-1:0] last_sum;
		logic [WIDTH-1:0] acc;
		int               n;
		int               loc;
		last_rd  = '0;
		last_sum = '0;
		for (int r = 0; r < n_rows; r++) begin
			n = (row_count[r] == '0) ? 1 : int'(row_count[r]); // zero counts as one.
			case (row_op[r])
				OP_WRITE: begin
					for (int i = 0; i < LANES; i++) begin
						if (row_wmask[r][i]) begin
							shadow[row_addr[r]][8*i +: 8] = row_wdata[r][8*i +: 8];
						end
					end
					row_exp_lat[r] = 1;
				end
				OP_READ: begin
					last_rd        = shadow[row_addr[r]];
					row_exp_lat[r] = 3;
				end
				OP_FILL: begin
					for (int k = 0; k < n; k++) begin
						loc         = (int'(row_addr[r]) + k) % DEPTH; // wraps at DEPTH.
						shadow[loc] = row_wdata[r] + WIDTH'(k);
					end
					row_exp_lat[r] = n;
				end
				default: begin
					acc = '0;
					for (int k = 0; k < n; k++) begin
						loc = (int'(row_addr[r]) + k) % DEPTH;
						acc = acc + shadow[loc]; // modulo 2^WIDTH.
					end
					last_sum       = acc;
					row_exp_lat[r] = n + 1; // extra drain cycle.
				end
			endcase
			row_exp_rdata[r] = last_rd; // both results hold between commands.
			row_exp_sum[r]   = last_sum;
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks_run++;
		assert (act === exp) else begin
			$display("Fail %s expected %h actual %h", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic run_row(input int r, output bit ok);
		bit idle;
		bit seen;
		int lat;
		ok   = 1'b0;
		idle = 1'b0;
		seen = 1'b0;
		lat  = 0;
		for (int k = 0; k < WAIT_LIMIT; k++) begin
			@(negedge clk);
			if (!busy) begin
				idle = 1'b1;
				break;
			end
		end
		assert (idle) else begin
			$display("Timeout: busy never dropped before command %s", row_name[r]);
			timeout_errors++;
		end
		if (!idle) return;
		@(posedge clk);
		start <= 1'b1;
		op    <= row_op[r];
		addr  <= row_addr[r];
		count <= row_count[r];
		wdata <= row_wdata[r];
		wmask <= row_wmask[r];
		for (int k = 1; k <= WAIT_LIMIT; k++) begin
			@(posedge clk);
			if (k == 1) start <= 1'b0;
			if (row_stray[r] && (k == 3)) begin
				start <= 1'b1; // must be dropped, FILL still running.
				op    <= OP_WRITE;
				wdata <= ~row_wdata[r];
				wmask <= '1;
			end
			if (row_stray[r] && (k == 4)) start <= 1'b0;
			@(negedge clk);
			if (done) begin
				seen = 1'b1;
				lat  = k - 1; // edge k-1 after the sampling edge.
				break;
			end
			assert (busy) else begin
				$display("busy was low while command %s was still running", row_name[r]);
				value_errors++;
			end
		end
		assert (seen) else begin
			$display("Timeout: done never arrived for command %s", row_name[r]);
			timeout_errors++;
		end
		if (!seen) return;
		check_value({row_name[r], " rdata"}, row_exp_rdata[r], rdata);
		check_value({row_name[r], " sum"}, row_exp_sum[r], sum);
		check_value({row_name[r], " latency"}, 32'(row_exp_lat[r]), 32'(lat));
		@(negedge clk);
		assert (!done) else begin
			$display("done stayed high for more than one cycle after %s", row_name[r]);
			value_errors++;
		end
		ok = 1'b1;
	endtask

	initial begin
		bit               ok;
		bit               alive;
		int               a;
		logic [WIDTH-1:0] d;
		logic [LANES-1:0] m;
		start          = 1'b0;
		op             = OP_READ;
		addr           = '0;
		count          = '0;
		wdata          = '0;
		wmask          = '0;
		n_rows         = 0;
		value_errors   = 0;
		timeout_errors = 0;
		checks_run     = 0;
		alive          = 1'b0;
		for (int i = 0; i < DEPTH; i++) shadow[i] = '0;

		// memory is all zero out of reset.
		add_row("reset_rd_00", OP_READ, 8'h00, 0, '0, '0, 0);
		add_row("reset_rd_ff", OP_READ, 8'hff, 0, '0, '0, 0);
		add_row("reset_rd_5a", OP_READ, 8'h5a, 0, '0, '0, 0);
		add_row("reset_sum", OP_CHECKSUM, 8'h00, 16, '0, '0, 0);
		for (int i = 0; i < 6; i++) begin
			a = $random(seed) & (DEPTH - 1);
			d = $random(seed);
			add_row($sformatf("wr_full_%0d", i), OP_WRITE, a, 0, d, '1, 0);
			add_row($sformatf("rd_full_%0d", i), OP_READ, a, 0, '0, '0, 0);
		end
		for (int i = 0; i < 4; i++) begin
			a = $random(seed) & (DEPTH - 1);
			d = $random(seed);
			m = LANES'($random(seed));
			if ((m == '0) || (m == '1)) m = 4'b0101; // keep it a real partial mask.
			add_row($sformatf("wr_base_%0d", i), OP_WRITE, a, 0, d, '1, 0);
			add_row($sformatf("wr_part_%0d", i), OP_WRITE, a, 0, ~d, m, 0);
			add_row($sformatf("rd_part_%0d", i), OP_READ, a, 0, '0, '0, 0);
		end
		add_row("fill_20", OP_FILL, 8'h20, 16, 32'h1000_0000, '0, 0);
		add_row("rd_fill_20", OP_READ, 8'h20, 0, '0, '0, 0);
		add_row("rd_fill_27", OP_READ, 8'h27, 0, '0, '0, 0);
		add_row("rd_fill_2f", OP_READ, 8'h2f, 0, '0, '0, 0);
		d = $random(seed);
		add_row("fill_wrap", OP_FILL, 8'hf8, 16, d, '0, 0); // f8 through 07.
		add_row("rd_wrap_fc", OP_READ, 8'hfc, 0, '0, '0, 0);
		add_row("rd_wrap_ff", OP_READ, 8'hff, 0, '0, '0, 0);
		add_row("rd_wrap_00", OP_READ, 8'h00, 0, '0, '0, 0);
		add_row("rd_wrap_07", OP_READ, 8'h07, 0, '0, '0, 0);
		add_row("fill_cnt0", OP_FILL, 8'h40, 0, 32'hcafe_0000, '0, 0);
		add_row("rd_cnt0_40", OP_READ, 8'h40, 0, '0, '0, 0);
		add_row("rd_cnt0_41", OP_READ, 8'h41, 0, '0, '0, 0);
		add_row("sum_fill_20", OP_CHECKSUM, 8'h20, 16, '0, '0, 0);
		add_row("sum_wrap", OP_CHECKSUM, 8'hf8, 16, '0, '0, 0);
		for (int i = 0; i < 8; i++) begin
			a = 8'h80 + ($random(seed) & 15);
			d = $random(seed);
			m = LANES'($random(seed));
			add_row($sformatf("wr_mix_%0d", i), OP_WRITE, a, 0, d, m, 0);
		end
		add_row("sum_mix", OP_CHECKSUM, 8'h80, 16, '0, '0, 0);
		add_row("sum_cnt0", OP_CHECKSUM, 8'h20, 0, '0, '0, 0);
		add_row("sum_all", OP_CHECKSUM, 8'h00, DEPTH, '0, '0, 0);
		d = $random(seed);
		add_row("fill_stray", OP_FILL, 8'h60, 24, d, '0, 1); // stray WRITE to 60.
		add_row("rd_stray_60", OP_READ, 8'h60, 0, '0, '0, 0);
		add_row("rd_stray_70", OP_READ, 8'h70, 0, '0, '0, 0);
		add_row("sum_stray", OP_CHECKSUM, 8'h60, 24, '0, '0, 0);
		add_row("sum_all_end", OP_CHECKSUM, 8'h00, DEPTH, '0, '0, 0);
		build_expected();

		for (int k = 0; k < WAIT_LIMIT; k++) begin
			@(negedge clk);
			if (arst_n) begin
				alive = 1'b1;
				break;
			end
		end
		assert (alive) else begin
			$display("Timeout: reset was never released");
			timeout_errors++;
		end
		if (alive) begin
			@(negedge clk);
			check_value("reset busy", 32'h0, 32'(busy));
			check_value("reset done", 32'h0, 32'(done));
			check_value("reset rdata", 32'h0, rdata);
			check_value("reset sum", 32'h0, sum);
			for (int r = 0; r < n_rows; r++) begin
				run_row(r, ok);
				if (!ok) break; // timed out, rest of the table is moot.
			end
		end

		$display("checks %0d, value errors %0d, timeouts %0d",
			checks_run, value_errors, timeout_errors);
		if ((value_errors == 0) && (timeout_errors == 0)) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule
